// ==== rtl/gba_load_params.svh ====
// Download path parameters
// Widths and fixed constants shared by the loader front end
`ifndef GBA_LOAD_PARAMS_SVH
`define GBA_LOAD_PARAMS_SVH

// ====================
// Host stream
// ====================
`define GBA_ADDR_W      27   // Host byte address
`define GBA_DATA_W      16   // Host data, one half-word per strobe

// ====================
// Consumers
// ====================
`define GBA_BIOS_AW     12   // BIOS word address, byte bits 13:2
`define GBA_CHEAT_W     128  // Flags, address, compare, replace
`define GBA_CHEAT_INDEX 255  // Download index reserved for cheats

// Cartridge header title
`define GBA_TITLE_LINE  10   // 16-byte line at 0xA0
`define GBA_TITLE_BYTES 12   // Title length in bytes
`define GBA_QUIRK_N     6    // Entries in the quirk table

`endif

// ==== rtl/gba_dl_pkg.sv ====
// Download stream types
// Classes of host download and the word slots of a cheat code
`default_nettype none

package gba_dl_pkg;

	// ====================
	// Download kinds
	// ====================
	typedef enum logic [1:0] {
		DL_NONE  = 2'd0, // No download running
		DL_BIOS  = 2'd1, // Index zero
		DL_CART  = 2'd2, // Any other index
		DL_CHEAT = 2'd3  // Index all ones
	} dl_kind_t;

	// ====================
	// Cheat word slots
	// ====================
	// Encoding equals byte offset bits 3:1 inside a 16-byte code
	typedef enum logic [2:0] {
		FLAGS_LO = 3'd0, // Offset 0
		FLAGS_HI = 3'd1, // Offset 2
		ADDR_LO  = 3'd2, // Offset 4
		ADDR_HI  = 3'd3, // Offset 6
		CMP_LO   = 3'd4, // Offset 8
		CMP_HI   = 3'd5, // Offset 10
		REPL_LO  = 3'd6, // Offset 12
		REPL_HI  = 3'd7  // Offset 14, completes the code
	} cheat_slot_t;

endpackage

`default_nettype wire

// ==== rtl/gba_cart_pkg.sv ====
// Cartridge property types
// Cart class, quirk classes and the title table for quirk matching
`default_nettype none

`include "gba_load_params.svh"

package gba_cart_pkg;

	// Cart class, straight from index bits 7:6
	typedef logic [1:0] cart_type_t;

	typedef enum logic [1:0] {
		QK_NONE       = 2'd0, // Plain cartridge
		QK_SRAM       = 2'd1, // SRAM/flash access disabled
		QK_SRAM_REMAP = 2'd2  // SRAM disabled plus memory remap
	} quirk_t;

	typedef struct packed {
		logic [`GBA_TITLE_BYTES*8-1:0] title; // ASCII, first char in top byte
		quirk_t                        quirk;
	} quirk_entry_t;

	// ====================
	// Title table
	// ====================
	// Short titles are padded with zero bytes on the right
	localparam quirk_entry_t QUIRK_TABLE [`GBA_QUIRK_N] = '{
		'{title: "ROCKY BOXING",             quirk: QK_SRAM},
		'{title: "DBZ TAIKETSU",             quirk: QK_SRAM},
		'{title: {"IRIDIONII", 24'h000000},  quirk: QK_SRAM},
		'{title: {"BOMBER MAN", 16'h0000},   quirk: QK_SRAM_REMAP}, // NES classics
		'{title: {"SUPER MARIO", 8'h00},     quirk: QK_SRAM_REMAP},
		'{title: {"ZELDA 1", 40'h0000000000}, quirk: QK_SRAM_REMAP}
	};

endpackage

`default_nettype wire

// ==== rtl/gba_dl_decode.sv ====
// Download stream decoder
// Registers the host download stream once and sorts it by index
// into BIOS, cartridge or cheat traffic, with start and end pulses
`timescale 1ns/10ps
`default_nettype none

`include "gba_load_params.svh"

module gba_dl_decode (
	input  wire logic                   clk_sys,
	input  wire logic                   reset,
	input  wire logic                   dl_active_i, // Download level from host
	input  wire logic [7:0]             dl_index_i,
	input  wire logic [`GBA_ADDR_W-1:0] dl_addr_i,
	input  wire logic [`GBA_DATA_W-1:0] dl_data_i,
	input  wire logic                   dl_wr_i,     // One-cycle write strobe
	output gba_dl_pkg::dl_kind_t        dl_kind_o,
	output logic      [7:0]             dl_index_o,
	output logic      [`GBA_ADDR_W-1:0] dl_addr_o,
	output logic      [`GBA_DATA_W-1:0] dl_data_o,
	output logic                        dl_wr_o,
	output logic                        dl_start_o,  // First registered cycle of a download
	output logic                        dl_end_o     // First registered cycle after it
);
	import gba_dl_pkg::*;

	localparam logic [7:0] CHEAT_INDEX = `GBA_CHEAT_INDEX;

	logic     active_q; // Previous registered download level
	dl_kind_t kind_d;

	// Classify the raw index, nothing while idle
	always_comb begin
		if (!dl_active_i)
			kind_d = DL_NONE;
		else if (dl_index_i == 8'd0)
			kind_d = DL_BIOS;
		else if (dl_index_i == CHEAT_INDEX)
			kind_d = DL_CHEAT;
		else
			kind_d = DL_CART; // Index bits 7:6 carry the cart class
	end

	// ====================
	// Control pipeline
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_q   <= 1'b0;
			dl_kind_o  <= DL_NONE;
			dl_wr_o    <= 1'b0;
			dl_start_o <= 1'b0;
			dl_end_o   <= 1'b0;
		end else begin
			active_q   <= dl_active_i;
			dl_kind_o  <= kind_d;
			dl_wr_o    <= dl_wr_i & dl_active_i; // Stray strobes outside a download dropped
			dl_start_o <= dl_active_i & ~active_q;  // Rising edge
			dl_end_o   <= ~dl_active_i & active_q;  // Falling edge
		end
	end

	// Payload copy, same cycle as the control bits
	always_ff @(posedge clk_sys) begin
		dl_index_o <= dl_index_i;
		dl_addr_o  <= dl_addr_i;
		dl_data_o  <= dl_data_i;
	end

endmodule

`default_nettype wire

// ==== rtl/gba_bios_pack.sv ====
// BIOS write packer
// Joins two 16-bit BIOS halves into one 32-bit word write
`timescale 1ns/10ps
`default_nettype none

`include "gba_load_params.svh"

module gba_bios_pack (
	input  wire logic                    clk_sys,
	input  wire logic                    reset,
	input  wire gba_dl_pkg::dl_kind_t    dl_kind_i,
	input  wire logic [`GBA_ADDR_W-1:0]  dl_addr_i,
	input  wire logic [`GBA_DATA_W-1:0]  dl_data_i,
	input  wire logic                    dl_wr_i,
	output logic      [`GBA_BIOS_AW-1:0] bios_addr_o, // Word address
	output logic      [31:0]             bios_data_o,
	output logic                         bios_wr_o    // One pulse per word
);
	import gba_dl_pkg::*;

	logic                   bios_wr_en;
	logic [`GBA_DATA_W-1:0] low_half; // Last half with address bit 1 clear

	assign bios_wr_en = dl_wr_i && (dl_kind_i == DL_BIOS);

	// Write pulse only needs reset
	always_ff @(posedge clk_sys) begin
		if (reset)
			bios_wr_o <= 1'b0;
		else
			bios_wr_o <= bios_wr_en & dl_addr_i[1]; // Upper half closes the word
	end

	// ====================
	// Word assembly
	// ====================
	always_ff @(posedge clk_sys) begin
		if (bios_wr_en) begin
			if (!dl_addr_i[1]) begin
				low_half <= dl_data_i; // Hold until the partner arrives
			end else begin
				bios_data_o <= {dl_data_i, low_half};
				bios_addr_o <= dl_addr_i[`GBA_BIOS_AW+1:2];
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/gba_cheat_assemble.sv ====
// Cheat code assembler
// Places eight 16-bit words into one 128-bit code by byte offset
// and pulses valid on the last word, clear at each cheat download
`timescale 1ns/10ps
`default_nettype none

`include "gba_load_params.svh"

module gba_cheat_assemble (
	input  wire logic                    clk_sys,
	input  wire logic                    reset,
	input  wire gba_dl_pkg::dl_kind_t    dl_kind_i,
	input  wire logic                    dl_start_i,
	input  wire logic [`GBA_ADDR_W-1:0]  dl_addr_i,
	input  wire logic [`GBA_DATA_W-1:0]  dl_data_i,
	input  wire logic                    dl_wr_i,
	output logic      [`GBA_CHEAT_W-1:0] cheat_code_o,
	output logic                         cheat_valid_o, // Code complete
	output logic                         cheat_clear_o  // Drop all held codes
);
	import gba_dl_pkg::*;

	logic        code_wr;
	cheat_slot_t slot;

	assign code_wr = dl_wr_i && (dl_kind_i == DL_CHEAT);
	assign slot    = cheat_slot_t'(dl_addr_i[3:1]); // Offset inside the 16-byte code

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_valid_o <= 1'b0;
			cheat_clear_o <= 1'b0;
		end else begin
			cheat_clear_o <= dl_start_i && (dl_kind_i == DL_CHEAT);
			cheat_valid_o <= code_wr && (slot == REPL_HI);
		end
	end

	// ====================
	// Slot placement
	// ====================
	// {flags, address, compare, replace} from bit 127 down, low word first in each field
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (slot)
				FLAGS_LO: cheat_code_o[111:96]  <= dl_data_i;
				FLAGS_HI: cheat_code_o[127:112] <= dl_data_i;
				ADDR_LO:  cheat_code_o[79:64]   <= dl_data_i;
				ADDR_HI:  cheat_code_o[95:80]   <= dl_data_i;
				CMP_LO:   cheat_code_o[47:32]   <= dl_data_i;
				CMP_HI:   cheat_code_o[63:48]   <= dl_data_i;
				REPL_LO:  cheat_code_o[15:0]    <= dl_data_i;
				REPL_HI:  cheat_code_o[31:16]   <= dl_data_i; // Valid fires with this one
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/gba_cart_scan.sv ====
// Cartridge scanner
// Watches cart download data for the 1M flash signature and the
// header title, picks compatibility quirks from the title and keeps
// the cart class, loaded flag and last written address
`timescale 1ns/10ps
`default_nettype none

`include "gba_load_params.svh"

module gba_cart_scan (
	input  wire logic                    clk_sys,
	input  wire logic                    reset,
	input  wire gba_dl_pkg::dl_kind_t    dl_kind_i,
	input  wire logic [7:0]              dl_index_i,
	input  wire logic                    dl_start_i,
	input  wire logic                    dl_end_i,
	input  wire logic [`GBA_ADDR_W-1:0]  dl_addr_i,
	input  wire logic [`GBA_DATA_W-1:0]  dl_data_i,
	input  wire logic                    dl_wr_i,
	output gba_cart_pkg::cart_type_t     cart_type_o,
	output logic                         cart_loaded_o,
	output logic                         flash_1m_o,     // "FLASH1M_V" seen in the image
	output logic      [`GBA_ADDR_W-3:0]  max_pak_addr_o, // Last word address, bits 26:2
	output logic                         sram_disable_o,
	output logic                         mem_remap_o
);
	import gba_dl_pkg::*;
	import gba_cart_pkg::*;

	localparam logic [71:0]               FLASH_SIG  = "FLASH1M_V";
	localparam logic [`GBA_ADDR_W-5:0]    TITLE_LINE = `GBA_TITLE_LINE;
	localparam logic [3:0]                TITLE_END  = `GBA_TITLE_BYTES; // Offset of lookup write
	localparam logic [3:0]                TITLE_TOP  = `GBA_TITLE_BYTES - 2;

	logic                          cart_wr;
	logic                          in_cart;   // Cart download running
	logic [63:0]                   history;   // Last eight bytes, oldest on top
	logic [`GBA_TITLE_BYTES*8-1:0] cart_id;   // Title being collected
	logic [`GBA_ADDR_W-1:0]        last_addr; // Most recent cart write
	logic                          title_hit;
	logic [6:0]                    title_lsb;
	logic                          sig_even;
	logic                          sig_odd;
	quirk_t                        quirk_hit;

	// Walk the table, last match wins
	function automatic quirk_t quirk_lookup(input logic [`GBA_TITLE_BYTES*8-1:0] id);
		quirk_t q;
		q = QK_NONE;
		for (int i = 0; i < `GBA_QUIRK_N; i++) begin
			if (QUIRK_TABLE[i].title == id)
				q = QUIRK_TABLE[i].quirk;
		end
		return q;
	endfunction

	assign cart_wr   = dl_wr_i && (dl_kind_i == DL_CART);
	assign title_hit = (dl_addr_i[`GBA_ADDR_W-1:4] == TITLE_LINE);
	assign title_lsb = {TITLE_TOP - dl_addr_i[3:0], 3'd0}; // First word lands on top
	assign quirk_hit = quirk_lookup(cart_id);

	// Signature ending on the low byte, or on the high byte of this word
	assign sig_even = ({history, dl_data_i[7:0]} == FLASH_SIG);
	assign sig_odd  = ({history[55:0], dl_data_i[7:0], dl_data_i[15:8]} == FLASH_SIG);

	// ====================
	// Cart properties
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			in_cart        <= 1'b0;
			cart_type_o    <= '0;
			cart_loaded_o  <= 1'b0;
			flash_1m_o     <= 1'b0;
			sram_disable_o <= 1'b0;
			mem_remap_o    <= 1'b0;
		end else begin
			if (dl_start_i && (dl_kind_i == DL_CART)) begin
				in_cart        <= 1'b1;
				cart_type_o    <= cart_type_t'(dl_index_i[7:6]);
				cart_loaded_o  <= 1'b1;
				flash_1m_o     <= 1'b0; // New image, fresh detection
				sram_disable_o <= 1'b0;
				mem_remap_o    <= 1'b0;
			end
			if (dl_end_i)
				in_cart <= 1'b0;

			if (cart_wr && (sig_even || sig_odd))
				flash_1m_o <= 1'b1;

			// Title complete, apply its class
			if (cart_wr && title_hit && (dl_addr_i[3:0] == TITLE_END)) begin
				sram_disable_o <= (quirk_hit != QK_NONE);
				mem_remap_o    <= (quirk_hit == QK_SRAM_REMAP);
			end
		end
	end

	// ====================
	// Data capture
	// ====================
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			history   <= {history[47:0], dl_data_i[7:0], dl_data_i[15:8]}; // Low byte is first
			last_addr <= dl_addr_i;
			if (title_hit && (dl_addr_i[3:0] < TITLE_END))
				cart_id[title_lsb +: 16] <= {dl_data_i[7:0], dl_data_i[15:8]}; // Byte swap
		end
		if (dl_end_i && in_cart)
			max_pak_addr_o <= last_addr[`GBA_ADDR_W-1:2];
	end

endmodule

`default_nettype wire

// ==== rtl/gba_loader_top.sv ====
// Download front end top level
// Registered host stream fans out to the BIOS packer, the cheat
// assembler and the cartridge scanner
`timescale 1ns/10ps
`default_nettype none

`include "gba_load_params.svh"

module gba_loader_top (
	input  wire logic                    clk_sys,
	input  wire logic                    reset,
	input  wire logic                    dl_active_i,
	input  wire logic [7:0]              dl_index_i,
	input  wire logic [`GBA_ADDR_W-1:0]  dl_addr_i,
	input  wire logic [`GBA_DATA_W-1:0]  dl_data_i,
	input  wire logic                    dl_wr_i,
	output logic      [`GBA_BIOS_AW-1:0] bios_addr_o,
	output logic      [31:0]             bios_data_o,
	output logic                         bios_wr_o,
	output logic      [`GBA_CHEAT_W-1:0] cheat_code_o,
	output logic                         cheat_valid_o,
	output logic                         cheat_clear_o,
	output gba_cart_pkg::cart_type_t     cart_type_o,
	output logic                         cart_loaded_o,
	output logic                         flash_1m_o,
	output logic      [`GBA_ADDR_W-3:0]  max_pak_addr_o,
	output logic                         sram_disable_o,
	output logic                         mem_remap_o
);
	import gba_dl_pkg::*;

	// Registered stream, shared by all consumers
	dl_kind_t               dl_kind;
	logic [7:0]             dl_index;
	logic [`GBA_ADDR_W-1:0] dl_addr;
	logic [`GBA_DATA_W-1:0] dl_data;
	logic                   dl_wr;
	logic                   dl_start;
	logic                   dl_end;

	gba_dl_decode dl_decode_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.dl_wr_i     (dl_wr_i),
		.dl_kind_o   (dl_kind),
		.dl_index_o  (dl_index),
		.dl_addr_o   (dl_addr),
		.dl_data_o   (dl_data),
		.dl_wr_o     (dl_wr),
		.dl_start_o  (dl_start),
		.dl_end_o    (dl_end)
	);

	gba_bios_pack bios_pack_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_kind_i   (dl_kind),
		.dl_addr_i   (dl_addr),
		.dl_data_i   (dl_data),
		.dl_wr_i     (dl_wr),
		.bios_addr_o (bios_addr_o),
		.bios_data_o (bios_data_o),
		.bios_wr_o   (bios_wr_o)
	);

	gba_cheat_assemble cheat_assemble_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dl_kind_i     (dl_kind),
		.dl_start_i    (dl_start),
		.dl_addr_i     (dl_addr),
		.dl_data_i     (dl_data),
		.dl_wr_i       (dl_wr),
		.cheat_code_o  (cheat_code_o),
		.cheat_valid_o (cheat_valid_o),
		.cheat_clear_o (cheat_clear_o)
	);

	gba_cart_scan cart_scan_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.dl_kind_i      (dl_kind),
		.dl_index_i     (dl_index),
		.dl_start_i     (dl_start),
		.dl_end_i       (dl_end),
		.dl_addr_i      (dl_addr),
		.dl_data_i      (dl_data),
		.dl_wr_i        (dl_wr),
		.cart_type_o    (cart_type_o),
		.cart_loaded_o  (cart_loaded_o),
		.flash_1m_o     (flash_1m_o),
		.max_pak_addr_o (max_pak_addr_o),
		.sram_disable_o (sram_disable_o),
		.mem_remap_o    (mem_remap_o)
	);

endmodule

`default_nettype wire

// ==== verif/tb_gba_loader.sv ====
// Download front end testbench
// Random host downloads checked against a model of the BIOS packer,
// cheat assembler and cartridge scanner, with exact pulse timing
`timescale 1ns/10ps
`default_nettype none

`include "gba_load_params.svh"

module tb_gba_loader;
	import gba_dl_pkg::*;
	import gba_cart_pkg::*;

	logic                    clk_sys;
	logic                    reset;
	logic                    dl_active_i;
	logic [7:0]              dl_index_i;
	logic [`GBA_ADDR_W-1:0]  dl_addr_i;
	logic [`GBA_DATA_W-1:0]  dl_data_i;
	logic                    dl_wr_i;
	logic [`GBA_BIOS_AW-1:0] bios_addr_o;
	logic [31:0]             bios_data_o;
	logic                    bios_wr_o;
	logic [`GBA_CHEAT_W-1:0] cheat_code_o;
	logic                    cheat_valid_o;
	logic                    cheat_clear_o;
	cart_type_t              cart_type_o;
	logic                    cart_loaded_o;
	logic                    flash_1m_o;
	logic [`GBA_ADDR_W-3:0]  max_pak_addr_o;
	logic                    sram_disable_o;
	logic                    mem_remap_o;

	// Scoreboard state
	int cyc;           // Falling edges since reset release
	int checks;
	int errors;
	int tests;
	int test_start_errors;
	int clear_due;     // Cycle of the expected cheat clear
	int bios_due [$];
	logic [11:0] bios_addr_q [$];
	logic [31:0] bios_data_q [$];
	int valid_due [$];
	logic [127:0] code_q [$];
	logic [127:0] mask_q [$];  // Slots written so far, older slots unknown
	logic [127:0] model_code;
	logic [127:0] model_mask;

	// Stimulus scratch
	int seed, i, j, k, c, s, pos, tmp, len, off, al, e;
	int perm [8];
	logic [11:0]  word;
	logic [15:0]  lo, hi;
	logic [26:0]  addr;
	logic [26:0]  base;
	logic [7:0]   idx;
	logic [95:0]  title;
	logic [71:0]  sig;
	logic [7:0]   raw [128]; // Base image shared by all flash runs
	logic [7:0]   img [128];
	quirk_t       qexp;

	gba_loader_top dut_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.dl_active_i    (dl_active_i),
		.dl_index_i     (dl_index_i),
		.dl_addr_i      (dl_addr_i),
		.dl_data_i      (dl_data_i),
		.dl_wr_i        (dl_wr_i),
		.bios_addr_o    (bios_addr_o),
		.bios_data_o    (bios_data_o),
		.bios_wr_o      (bios_wr_o),
		.cheat_code_o   (cheat_code_o),
		.cheat_valid_o  (cheat_valid_o),
		.cheat_clear_o  (cheat_clear_o),
		.cart_type_o    (cart_type_o),
		.cart_loaded_o  (cart_loaded_o),
		.flash_1m_o     (flash_1m_o),
		.max_pak_addr_o (max_pak_addr_o),
		.sram_disable_o (sram_disable_o),
		.mem_remap_o    (mem_remap_o)
	);

	always #50 clk_sys = ~clk_sys; // 100 ns period

	// ====================
	// Checking helpers
	// ====================
	task automatic check(input string name, input logic [127:0] exp, input logic [127:0] got);
		checks++;
		if (exp !== got) begin
			errors++;
			$display("ERROR %s expected %0h got %0h", name, exp, got);
		end
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("FAILURE: %s", msg);
	endtask

	// Pulses are compared every cycle against the due stamps
	task automatic check_outputs();
		logic bios_exp;
		logic valid_exp;
		bios_exp  = (bios_due.size() > 0) && (bios_due[0] == cyc);
		valid_exp = (valid_due.size() > 0) && (valid_due[0] == cyc);
		check("bios_wr_o", bios_exp, bios_wr_o);
		if (bios_exp) begin
			check("bios_addr_o", bios_addr_q[0], bios_addr_o);
			check("bios_data_o", bios_data_q[0], bios_data_o);
			bios_due.delete(0);
			bios_addr_q.delete(0);
			bios_data_q.delete(0);
		end
		check("cheat_valid_o", valid_exp, cheat_valid_o);
		if (valid_exp) begin
			check("cheat_code_o", code_q[0], cheat_code_o & mask_q[0]);
			valid_due.delete(0);
			code_q.delete(0);
			mask_q.delete(0);
		end
		check("cheat_clear_o", cyc == clear_due, cheat_clear_o);
	endtask

	function automatic bit pending();
		return (bios_due.size() > 0) || (valid_due.size() > 0) || (clear_due > cyc);
	endfunction

	// ====================
	// Stimulus helpers
	// ====================
	// One cycle, inputs change on the falling edge
	task automatic step();
		@(negedge clk_sys);
		cyc++;
		check_outputs();
		dl_wr_i = 1'b0; // Strobe lasts one cycle
	endtask

	task automatic idle(input int n);
		repeat (n) step();
	endtask

	task automatic write_word(input logic [26:0] a, input logic [15:0] d);
		step();
		dl_addr_i = a;
		dl_data_i = d;
		dl_wr_i   = 1'b1;
	endtask

	task automatic dl_begin(input logic [7:0] index);
		step();
		dl_index_i  = index;
		dl_active_i = 1'b1;
		if (index == 8'hFF)
			clear_due = cyc + 2; // Start pulse, then clear
	endtask

	task automatic dl_finish();
		step();
		dl_active_i = 1'b0;
	endtask

	// Wait out in-flight pulses
	task automatic drain();
		int n;
		n = 0;
		while (pending() && n < 10) begin
			step();
			n++;
		end
		if (pending()) begin
			report_failure("expected output pulses did not arrive within 10 cycles");
			bios_due.delete();
			bios_addr_q.delete();
			bios_data_q.delete();
			valid_due.delete();
			code_q.delete();
			mask_q.delete();
			clear_due = -1;
		end
	endtask

	// Start clears flash and quirks, latches type and loaded
	task automatic cart_begin(input logic [7:0] index);
		dl_begin(index);
		idle(2);
		check("cart_type_o", index[7:6], cart_type_o);
		check("cart_loaded_o", 1'b1, cart_loaded_o);
		check("flash_1m_o", 1'b0, flash_1m_o);
		check("sram_disable_o", 1'b0, sram_disable_o);
		check("mem_remap_o", 1'b0, mem_remap_o);
	endtask

	task automatic cart_end(input logic [26:0] last);
		dl_finish();
		idle(2);
		check("max_pak_addr_o", last[26:2], max_pak_addr_o);
	endtask

	task automatic wait_flash();
		int n;
		n = 0;
		while (flash_1m_o !== 1'b1 && n < 2) begin
			step();
			n++;
		end
		if (flash_1m_o !== 1'b1)
			report_failure("flash_1m_o did not rise within 2 cycles of the signature");
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == test_start_errors)
			$display("Test %0d %s: pass", tests, name);
		else
			$display("Test %0d %s: %0d errors", tests, name, errors - test_start_errors);
		test_start_errors = errors;
	endtask

	// ====================
	// Test sequence
	// ====================
	initial begin
		seed = $urandom(94);
		clk_sys = 1'b0;
		reset = 1'b1;
		dl_active_i = 1'b0;
		dl_index_i = 8'd0;
		dl_addr_i = '0;
		dl_data_i = '0;
		dl_wr_i = 1'b0;
		cyc = 0;
		checks = 0;
		errors = 0;
		tests = 0;
		test_start_errors = 0;
		clear_due = -1;
		model_code = '0;
		model_mask = '0;
		sig = "FLASH1M_V";
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		// 1: reset values
		check("bios_wr_o", 1'b0, bios_wr_o);
		check("cheat_valid_o", 1'b0, cheat_valid_o);
		check("cheat_clear_o", 1'b0, cheat_clear_o);
		check("cart_loaded_o", 1'b0, cart_loaded_o);
		check("flash_1m_o", 1'b0, flash_1m_o);
		check("sram_disable_o", 1'b0, sram_disable_o);
		check("mem_remap_o", 1'b0, mem_remap_o);
		end_test("reset values");

		// 2: BIOS packing, lower half then upper half per word
		dl_begin(8'd0);
		for (i = 0; i < 64; i++) begin
			word = 12'($urandom);
			lo   = 16'($urandom);
			hi   = 16'($urandom);
			idle($urandom % 3);
			write_word({13'd0, word, 2'b00}, lo);
			idle($urandom % 3);
			write_word({13'd0, word, 2'b10}, hi);
			bios_due.push_back(cyc + 2);
			bios_addr_q.push_back(word);
			bios_data_q.push_back({hi, lo});
		end
		dl_finish();
		drain();
		end_test("BIOS packing");

		// 3: cheat codes in shuffled slot order
		dl_begin(8'hFF);
		for (c = 0; c < 5; c++) begin
			for (j = 0; j < 8; j++)
				perm[j] = j;
			for (j = 7; j > 0; j--) begin
				k = $urandom % (j + 1);
				tmp = perm[j];
				perm[j] = perm[k];
				perm[k] = tmp;
			end
			for (j = 0; j < 8; j++) begin
				s   = perm[j];
				lo  = 16'($urandom);
				pos = (3 - s / 2) * 32 + (s % 2) * 16; // Field from top, low word first
				idle($urandom % 3);
				write_word(27'(c * 16 + s * 2), lo);
				model_code[pos +: 16] = lo;
				model_mask[pos +: 16] = 16'hFFFF;
				if (cheat_slot_t'(s) == REPL_HI) begin
					valid_due.push_back(cyc + 2);
					code_q.push_back(model_code & model_mask);
					mask_q.push_back(model_mask);
				end
			end
			idle(2);
			check("cheat_code_o", model_code, cheat_code_o);
		end
		dl_finish();
		drain();
		end_test("cheat codes");

		// 4: cart type, loaded flag and last address
		for (k = 0; k < 4; k++) begin
			idx = {2'($urandom), 6'($urandom)};
			if (idx == 8'h00)
				idx = 8'h01;
			if (idx == 8'hFF)
				idx = 8'hFE;
			cart_begin(idx);
			len  = 1 + $urandom % 24;
			base = {26'($urandom), 1'b0};
			for (j = 0; j < len; j++) begin
				addr = base + 27'(2 * j);
				write_word(addr, 16'($urandom));
				idle($urandom % 2);
			end
			cart_end(addr);
		end
		end_test("cart properties");

		// 5: flash signature at even, odd, then no offset
		for (j = 0; j < 128; j++)
			raw[j] = 8'($urandom);
		for (al = 0; al < 3; al++) begin
			cart_begin(8'h40);
			for (j = 0; j < 128; j++)
				img[j] = raw[j];
			off = 2 * ($urandom % 50) + al;
			if (al < 2) begin
				for (j = 0; j < 9; j++)
					img[off + j] = sig[71 - 8 * j -: 8];
			end
			for (j = 0; j < 64; j++) begin
				write_word(27'(2 * j), {img[2 * j + 1], img[2 * j]}); // First byte in low half
				if (al < 2 && j == (off + 8) / 2)
					wait_flash();
			end
			cart_end(27'd126);
			check("flash_1m_o", al < 2, flash_1m_o);
		end
		end_test("flash detection");

		// 6: quirk lookup from the header title
		for (e = 0; e <= `GBA_QUIRK_N; e++) begin
			if (e < `GBA_QUIRK_N) begin
				title = QUIRK_TABLE[e].title;
				qexp  = QUIRK_TABLE[e].quirk;
			end else begin
				for (j = 0; j < 12; j++)
					title[95 - 8 * j -: 8] = 8'(65 + $urandom % 26);
				qexp = QK_NONE; // Letters only, no table title has that
			end
			cart_begin(8'h21);
			for (j = 0; j < 6; j++)
				write_word(27'(`GBA_TITLE_LINE * 16 + 2 * j),
					{title[87 - 16 * j -: 8], title[95 - 16 * j -: 8]});
			write_word(27'(`GBA_TITLE_LINE * 16 + 12), 16'($urandom)); // Triggers lookup
			idle(2);
			check("sram_disable_o", qexp != QK_NONE, sram_disable_o);
			check("mem_remap_o", qexp == QK_SRAM_REMAP, mem_remap_o);
			cart_end(27'(`GBA_TITLE_LINE * 16 + 12));
		end
		end_test("quirks");

		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+rtl
rtl/gba_dl_pkg.sv
rtl/gba_cart_pkg.sv
rtl/gba_dl_decode.sv
rtl/gba_bios_pack.sv
rtl/gba_cheat_assemble.sv
rtl/gba_cart_scan.sv
rtl/gba_loader_top.sv
verif/tb_gba_loader.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the download front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f compile.f \
	--top-module tb_gba_loader -Mdir obj_dir -o tb_gba_loader
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_gba_loader > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
